/* Makefile */
# Verilator build and run for the pipelined core

VERILATOR ?= verilator
TOP       ?= pipeCpuTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert
RUNFLAGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)
PASSMSG := *** TEST PASSED ***

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNFLAGS))"; echo "$$out"; echo "$$out" | grep -qF '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)

/* build.f */
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/stageReg.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/pipeCpu.sv
testbench/pipeCpu_chk.sv
testbench/pipeCpuTb.sv

/* rtl/decodeStage.sv */
`default_nettype none

module decodeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire instr_t instr,
    input  wire word_t  pcPlus4,
    input  wire word_t  rsData,
    input  wire word_t  rtData,
    output regAddr_t    rsAddr,
    output regAddr_t    rtAddr,
    output logic        rsUsed,
    output logic        rtUsed,
    output logic        branchTaken,
    output word_t       branchTarget,
    output idExe_t      ctrl
);

    logic [opW-1:0]     opcode;
    logic [functW-1:0]  funct;
    regAddr_t           rdAddr;
    logic [immW-1:0]    imm16;
    logic [jIndexW-1:0] jIndex;
    logic               immZero;
    logic               wena;
    regAddr_t           dest;
    word_t              brTarget;
    word_t              jTarget;

    assign opcode = instr[opLsb +: opW];
    assign funct  = instr[0 +: functW];
    assign rsAddr = instr[rsLsb +: regAddrW];
    assign rtAddr = instr[rtLsb +: regAddrW];
    assign rdAddr = instr[rdLsb +: regAddrW];
    assign imm16  = instr[0 +: immW];
    assign jIndex = instr[0 +: jIndexW];

    assign brTarget = pcPlus4 + {{(dataW-immW-2){imm16[immW-1]}}, imm16, 2'b00};
    assign jTarget  = {pcPlus4[dataW-1 -: 4], jIndex, 2'b00};

    assign branchTaken = (opcode == opBeq && rsData == rtData) ||
                         (opcode == opBne && rsData != rtData) ||
                         (opcode == opJ);
    assign branchTarget = (opcode == opJ) ? jTarget : brTarget;

    always_comb begin
        ctrl    = '0;
        rsUsed  = 1'b0;
        rtUsed  = 1'b0;
        immZero = 1'b0;
        wena    = 1'b0;
        dest    = rtAddr; // rd only for R-type
        ctrl.aluOp = aluAdd;
        case (opcode)
            opSpecial: begin
                dest   = rdAddr;
                wena   = 1'b1;
                rsUsed = 1'b1;
                rtUsed = 1'b1;
                case (funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnXor:  ctrl.aluOp = aluXor;
                    fnNor:  ctrl.aluOp = aluNor;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSltu: ctrl.aluOp = aluSltu;
                    fnSll, fnSrl, fnSra: begin
                        rsUsed = 1'b0;
                        ctrl.srcAShamt = 1'b1;
                        ctrl.aluOp = (funct == fnSll) ? aluSll :
                                     (funct == fnSrl) ? aluSrl : aluSra;
                    end
                    default: wena = 1'b0; // unsupported funct acts as nop
                endcase
            end
            opAddiu, opSlti, opAndi, opOri, opXori, opLui, opLw: begin
                wena = 1'b1;
                rsUsed = (opcode != opLui);
                ctrl.srcBImm = 1'b1;
                immZero = (opcode == opAndi) || (opcode == opOri) ||
                          (opcode == opXori) || (opcode == opLui);
                ctrl.memRead = (opcode == opLw);
                case (opcode)
                    opSlti:  ctrl.aluOp = aluSlt;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    opLui:   ctrl.aluOp = aluLui;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opSw: begin
                rsUsed = 1'b1;
                rtUsed = 1'b1;
                ctrl.srcBImm  = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq, opBne: begin
                rsUsed = 1'b1;
                rtUsed = 1'b1;
            end
            default: ;
        endcase
        ctrl.rsData  = rsData;
        ctrl.rtData  = rtData;
        ctrl.shamt   = instr[shamtLsb +: shamtW];
        ctrl.imm     = immZero ? {{(dataW-immW){1'b0}}, imm16}
                               : {{(dataW-immW){imm16[immW-1]}}, imm16};
        ctrl.dest    = dest;
        ctrl.regWena = wena && (dest != '0); // r0 writes dropped here
    end

endmodule

`default_nettype wire

/* rtl/executeStage.sv */
`default_nettype none

module executeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire idExe_t ctrl,
    output exeMem_t     result
);

    word_t             opA;
    word_t             opB;
    word_t             aluOut;
    logic [shamtW-1:0] shiftAmt;

    assign opA = ctrl.srcAShamt ? {{(dataW-shamtW){1'b0}}, ctrl.shamt} : ctrl.rsData;
    assign opB = ctrl.srcBImm ? ctrl.imm : ctrl.rtData;
    assign shiftAmt = opA[shamtW-1:0];

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluOut = opA + opB;
            aluSub:  aluOut = opA - opB;
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluXor:  aluOut = opA ^ opB;
            aluNor:  aluOut = ~(opA | opB);
            aluSlt:  aluOut = {{(dataW-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu: aluOut = {{(dataW-1){1'b0}}, opA < opB};
            aluSll:  aluOut = opB << shiftAmt;
            aluSrl:  aluOut = opB >> shiftAmt;
            aluSra:  aluOut = $signed(opB) >>> shiftAmt;
            aluLui:  aluOut = {opB[immW-1:0], {(dataW-immW){1'b0}}};
            default: aluOut = '0;
        endcase
    end

    assign result.aluResult = aluOut;
    assign result.storeData = ctrl.rtData;
    assign result.dest      = ctrl.dest;
    assign result.regWena   = ctrl.regWena;
    assign result.memRead   = ctrl.memRead;
    assign result.memWrite  = ctrl.memWrite;

endmodule

`default_nettype wire

/* rtl/fetchStage.sv */
`default_nettype none

module fetchStage
    import isaPkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  stall,
    input  wire logic  branchTaken,
    input  wire word_t branchTarget,
    output word_t      pc,
    output word_t      pcPlus4
);

    word_t nextPc;

    assign pcPlus4 = pc + 32'd4;

    // a branch stuck behind a hazard waits until its operands are ready
    always_comb begin
        if (stall) begin
            nextPc = pc;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* rtl/hazardUnit.sv */
`default_nettype none

module hazardUnit
    import isaPkg::*;
(
    input  wire regAddr_t rsAddr,
    input  wire regAddr_t rtAddr,
    input  wire logic     rsUsed,
    input  wire logic     rtUsed,
    input  wire regAddr_t exeDest,
    input  wire regAddr_t memDest,
    input  wire logic     exeWena,
    input  wire logic     memWena,
    output logic          stall
);

    logic exePending;
    logic memPending;
    logic rsHit;
    logic rtHit;

    // no forwarding, so any pending producer blocks decode
    assign exePending = exeWena && exeDest != '0;
    assign memPending = memWena && memDest != '0;

    assign rsHit = rsUsed && ((exePending && exeDest == rsAddr) ||
                              (memPending && memDest == rsAddr));
    assign rtHit = rtUsed && ((exePending && exeDest == rtAddr) ||
                              (memPending && memDest == rtAddr));

    assign stall = rsHit || rtHit;

endmodule

`default_nettype wire

/* rtl/isaPkg.sv */
`default_nettype none

package isaPkg;

    localparam int dataW    = 32;
    localparam int regAddrW = 5;
    localparam int numRegs  = 32;

    // field positions
    localparam int opLsb    = 26;
    localparam int rsLsb    = 21;
    localparam int rtLsb    = 16;
    localparam int rdLsb    = 11;
    localparam int shamtLsb = 6;
    localparam int opW      = 6;
    localparam int functW   = 6;
    localparam int shamtW   = 5;
    localparam int immW     = 16;
    localparam int jIndexW  = 26;

    localparam logic [opW-1:0] opSpecial = 6'h00;
    localparam logic [opW-1:0] opJ       = 6'h02;
    localparam logic [opW-1:0] opBeq     = 6'h04;
    localparam logic [opW-1:0] opBne     = 6'h05;
    localparam logic [opW-1:0] opAddiu   = 6'h09;
    localparam logic [opW-1:0] opSlti    = 6'h0a;
    localparam logic [opW-1:0] opAndi    = 6'h0c;
    localparam logic [opW-1:0] opOri     = 6'h0d;
    localparam logic [opW-1:0] opXori    = 6'h0e;
    localparam logic [opW-1:0] opLui     = 6'h0f;
    localparam logic [opW-1:0] opLw      = 6'h23;
    localparam logic [opW-1:0] opSw      = 6'h2b;

    localparam logic [functW-1:0] fnSll  = 6'h00;
    localparam logic [functW-1:0] fnSrl  = 6'h02;
    localparam logic [functW-1:0] fnSra  = 6'h03;
    localparam logic [functW-1:0] fnAddu = 6'h21;
    localparam logic [functW-1:0] fnSubu = 6'h23;
    localparam logic [functW-1:0] fnAnd  = 6'h24;
    localparam logic [functW-1:0] fnOr   = 6'h25;
    localparam logic [functW-1:0] fnXor  = 6'h26;
    localparam logic [functW-1:0] fnNor  = 6'h27;
    localparam logic [functW-1:0] fnSlt  = 6'h2a;
    localparam logic [functW-1:0] fnSltu = 6'h2b;

    typedef logic [dataW-1:0]    word_t;
    typedef logic [regAddrW-1:0] regAddr_t;
    typedef logic [dataW-1:0]    instr_t;

endpackage

`default_nettype wire

/* rtl/memoryStage.sv */
`default_nettype none

module memoryStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire logic    clk,
    input  wire exeMem_t ctrl,
    output memWb_t       result
);

    word_t                dmem [dmemWords];
    logic [dmemAddrW-1:0] wordIdx;

    assign wordIdx = ctrl.aluResult[dmemAddrW+1:2]; // byte offset ignored

    always_ff @(posedge clk) begin
        if (ctrl.memWrite) begin
            dmem[wordIdx] <= ctrl.storeData;
        end
    end

    assign result.result  = ctrl.memRead ? dmem[wordIdx] : ctrl.aluResult;
    assign result.dest    = ctrl.dest;
    assign result.regWena = ctrl.regWena;

endmodule

`default_nettype wire

/* rtl/pipeCpu.sv */
`default_nettype none

module pipeCpu
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    output word_t       imemAddr,
    input  wire instr_t imemData,
    output logic        wbValid,
    output regAddr_t    wbAddr,
    output word_t       wbData
);

    word_t    pc;
    word_t    pcPlus4;
    logic     stall;
    logic     branchTaken;
    logic     flush;
    word_t    branchTarget;
    regAddr_t rsAddr;
    regAddr_t rtAddr;
    word_t    rsData;
    word_t    rtData;
    logic     rsUsed;
    logic     rtUsed;
    ifId_t    ifIdD;
    ifId_t    ifIdQ;
    idExe_t   idCtrl;
    idExe_t   idExeQ;
    exeMem_t  exeResult;
    exeMem_t  exeMemQ;
    memWb_t   memResult;
    memWb_t   memWbQ;

    assign imemAddr      = pc;
    assign ifIdD.pcPlus4 = pcPlus4;
    assign ifIdD.instr   = imemData;
    assign flush         = branchTaken && !stall; // squash the fetch behind it

    fetchStage fetch0 (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pc           (pc),
        .pcPlus4      (pcPlus4)
    );

    stageReg #(.payload_t(ifId_t)) ifId (
        .clk (clk), .rst (rst), .load (!stall), .bubble (flush), .d (ifIdD), .q (ifIdQ)
    );

    decodeStage decode0 (
        .instr        (ifIdQ.instr),
        .pcPlus4      (ifIdQ.pcPlus4),
        .rsData       (rsData),
        .rtData       (rtData),
        .rsAddr       (rsAddr),
        .rtAddr       (rtAddr),
        .rsUsed       (rsUsed),
        .rtUsed       (rtUsed),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .ctrl         (idCtrl)
    );

    regFile regs0 (
        .clk    (clk),
        .rst    (rst),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData),
        .wena   (memWbQ.regWena),
        .waddr  (memWbQ.dest),
        .wdata  (memWbQ.result)
    );

    hazardUnit hazard0 (
        .rsAddr  (rsAddr),
        .rtAddr  (rtAddr),
        .rsUsed  (rsUsed),
        .rtUsed  (rtUsed),
        .exeDest (idExeQ.dest),
        .memDest (exeMemQ.dest),
        .exeWena (idExeQ.regWena),
        .memWena (exeMemQ.regWena),
        .stall   (stall)
    );

    stageReg #(.payload_t(idExe_t)) idExe (
        .clk (clk), .rst (rst), .load (1'b1), .bubble (stall), .d (idCtrl), .q (idExeQ)
    );

    executeStage execute0 (
        .ctrl   (idExeQ),
        .result (exeResult)
    );

    stageReg #(.payload_t(exeMem_t)) exeMem (
        .clk (clk), .rst (rst), .load (1'b1), .bubble (1'b0), .d (exeResult), .q (exeMemQ)
    );

    memoryStage memory0 (
        .clk    (clk),
        .ctrl   (exeMemQ),
        .result (memResult)
    );

    stageReg #(.payload_t(memWb_t)) memWb (
        .clk (clk), .rst (rst), .load (1'b1), .bubble (1'b0), .d (memResult), .q (memWbQ)
    );

    // decode never enables a write to r0
    assign wbValid = memWbQ.regWena;
    assign wbAddr  = memWbQ.dest;
    assign wbData  = memWbQ.result;

endmodule

`default_nettype wire

/* rtl/pipePkg.sv */
`default_nettype none

package pipePkg;

    import isaPkg::*;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOp_t;

    localparam int dmemWords = 256;
    localparam int dmemAddrW = $clog2(dmemWords);

    typedef struct packed {
        word_t  pcPlus4;
        instr_t instr;
    } ifId_t;

    typedef struct packed {
        word_t              rsData;
        word_t              rtData;
        word_t              imm;
        logic [shamtW-1:0]  shamt;
        aluOp_t             aluOp;
        logic               srcAShamt; // operand A from shamt instead of rs
        logic               srcBImm;   // operand B from imm instead of rt
        regAddr_t           dest;
        logic               regWena;
        logic               memRead;
        logic               memWrite;
    } idExe_t;

    typedef struct packed {
        word_t    aluResult;
        word_t    storeData;
        regAddr_t dest;
        logic     regWena;
        logic     memRead;
        logic     memWrite;
    } exeMem_t;

    typedef struct packed {
        word_t    result;
        regAddr_t dest;
        logic     regWena;
    } memWb_t;

endpackage

`default_nettype wire

/* rtl/regFile.sv */
`default_nettype none

module regFile
    import isaPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire regAddr_t rsAddr,
    input  wire regAddr_t rtAddr,
    output word_t         rsData,
    output word_t         rtData,
    input  wire logic     wena,
    input  wire regAddr_t waddr,
    input  wire word_t    wdata
);

    word_t regs [1:numRegs-1]; // r0 has no storage

    // write-through so decode sees this cycle's write-back
    assign rsData = (rsAddr == '0) ? '0 :
                    (wena && waddr == rsAddr) ? wdata : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (wena && waddr == rtAddr) ? wdata : regs[rtAddr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wena && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* rtl/stageReg.sv */
`default_nettype none

module stageReg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     load,
    input  wire logic     bubble,
    input  wire payload_t d,
    output payload_t      q
);

    // all-zero payload is a nop with every enable low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '0;
        end else if (bubble) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* testbench/pipeCpuTb.sv */
`default_nettype none

module pipeCpuTb
    import isaPkg::*;
();

    localparam int maxRows     = 64;
    localparam int resetCycles = 16;
    localparam int drainCycles = 20;

    logic        clk;
    logic        rst;
    word_t       imemAddr;
    instr_t      imemData;
    logic        wbValid;
    regAddr_t    wbAddr;
    word_t       wbData;
    logic [29:0] imemIdx;

    instr_t      progMem [maxRows];
    logic        expWrite [maxRows];
    regAddr_t    expReg [maxRows];
    word_t       expVal [maxRows];
    string       testName [maxRows];
    int          numRows;
    int          mismatches;
    int          unexpected;
    int          assertFails;

    pipeCpu dut0 (
        .clk      (clk),
        .rst      (rst),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbValid  (wbValid),
        .wbAddr   (wbAddr),
        .wbData   (wbData)
    );

    always #2 clk = ~clk;

    assign imemIdx  = imemAddr[31:2];
    assign imemData = (imemIdx < 30'(numRows)) ? progMem[imemIdx[5:0]] : '0; // nop past the end

    function automatic instr_t rType(logic [5:0] fn, int rs, int rt, int rd, int sh);
        return {opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic instr_t iType(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic instr_t jType(int index);
        return {opJ, 26'(index)};
    endfunction

    task automatic addRow(instr_t ins, logic wr, int rd, word_t val, string name);
        progMem[numRows]  = ins;
        expWrite[numRows] = wr;
        expReg[numRows]   = 5'(rd);
        expVal[numRows]   = val;
        testName[numRows] = name;
        numRows++;
    endtask

    task automatic buildProgram();
        word_t rndA;
        word_t rndB;
        rndA = $urandom();
        rndB = $urandom();
        for (int i = 0; i < maxRows; i++) begin
            progMem[i]  = '0;
            expWrite[i] = 1'b0;
        end
        numRows = 0;
        addRow(iType(opAddiu, 0, 1, 16'd5), 1'b1, 1, 32'd5, "addiu");
        addRow(iType(opAddiu, 0, 2, 16'hfffd), 1'b1, 2, 32'hfffffffd, "addiuNeg");
        addRow(rType(fnAddu, 1, 2, 3, 0), 1'b1, 3, 32'd2, "adduDep"); // waits on r2
        addRow(rType(fnSubu, 1, 2, 4, 0), 1'b1, 4, 32'd8, "subu");
        addRow(rType(fnAnd, 1, 2, 5, 0), 1'b1, 5, 32'd5, "and");
        addRow(rType(fnOr, 1, 2, 6, 0), 1'b1, 6, 32'hfffffffd, "or");
        addRow(rType(fnXor, 1, 2, 7, 0), 1'b1, 7, 32'hfffffff8, "xor");
        addRow(rType(fnNor, 1, 2, 8, 0), 1'b1, 8, 32'd2, "nor");
        addRow(rType(fnSlt, 2, 1, 9, 0), 1'b1, 9, 32'd1, "sltSigned");
        addRow(rType(fnSltu, 2, 1, 10, 0), 1'b1, 10, 32'd0, "sltuUnsigned");
        addRow(rType(fnSll, 0, 2, 11, 4), 1'b1, 11, 32'hffffffd0, "sll");
        addRow(rType(fnSrl, 0, 2, 12, 28), 1'b1, 12, 32'h0000000f, "srl");
        addRow(rType(fnSra, 0, 2, 13, 1), 1'b1, 13, 32'hfffffffe, "sra");
        addRow(iType(opLui, 0, 14, 16'h8001), 1'b1, 14, 32'h80010000, "lui");
        addRow(iType(opOri, 14, 14, 16'h00ff), 1'b1, 14, 32'h800100ff, "oriDep");
        addRow(iType(opAndi, 14, 15, 16'hf0f0), 1'b1, 15, 32'h000000f0, "andiZext");
        addRow(iType(opXori, 2, 16, 16'hffff), 1'b1, 16, 32'hffff0002, "xoriZext");
        addRow(iType(opSlti, 2, 17, 16'hfffe), 1'b1, 17, 32'd1, "slti");
        addRow(iType(opAddiu, 1, 0, 16'd7), 1'b0, 0, 32'd0, "r0Write");
        addRow(rType(fnAddu, 0, 1, 18, 0), 1'b1, 18, 32'd5, "r0Read");
        addRow(iType(opSw, 0, 1, 16'd8), 1'b0, 0, 32'd0, "swFirst");
        addRow(iType(opSw, 0, 14, 16'd12), 1'b0, 0, 32'd0, "swSecond");
        addRow(iType(opLw, 0, 19, 16'd12), 1'b1, 19, 32'h800100ff, "lwAfterSw");
        addRow(iType(opLw, 0, 20, 16'd8), 1'b1, 20, 32'd5, "lwEarlierStore");
        addRow(iType(opBeq, 1, 18, 16'd1), 1'b0, 0, 32'd0, "beqTaken");
        addRow(iType(opAddiu, 0, 21, 16'd1), 1'b0, 0, 32'd0, "squashBeq");
        addRow(iType(opBne, 1, 18, 16'd1), 1'b0, 0, 32'd0, "bneNotTaken");
        addRow(iType(opAddiu, 0, 21, 16'd2), 1'b1, 21, 32'd2, "afterBne");
        addRow(iType(opBeq, 1, 2, 16'd1), 1'b0, 0, 32'd0, "beqNotTaken");
        addRow(iType(opAddiu, 0, 22, 16'd3), 1'b1, 22, 32'd3, "afterBeq");
        addRow(iType(opBne, 21, 22, 16'd2), 1'b0, 0, 32'd0, "bneTakenDep"); // stalls on r22
        addRow(iType(opAddiu, 0, 23, 16'd4), 1'b0, 0, 32'd0, "squashBne");
        addRow(iType(opAddiu, 0, 24, 16'd5), 1'b0, 0, 32'd0, "skippedBne");
        addRow(jType(numRows + 2), 1'b0, 0, 32'd0, "jump");
        addRow(iType(opAddiu, 0, 24, 16'd6), 1'b0, 0, 32'd0, "squashJump");
        addRow(iType(opLui, 0, 25, rndA[31:16]), 1'b1, 25, {rndA[31:16], 16'h0}, "rndLuiA");
        addRow(iType(opOri, 25, 25, rndA[15:0]), 1'b1, 25, rndA, "rndOriA");
        addRow(iType(opLui, 0, 26, rndB[31:16]), 1'b1, 26, {rndB[31:16], 16'h0}, "rndLuiB");
        addRow(iType(opOri, 26, 26, rndB[15:0]), 1'b1, 26, rndB, "rndOriB");
        addRow(rType(fnAddu, 25, 26, 27, 0), 1'b1, 27, rndA + rndB, "rndAddu");
        addRow(rType(fnSubu, 25, 26, 28, 0), 1'b1, 28, rndA - rndB, "rndSubu");
        addRow(rType(fnXor, 25, 26, 29, 0), 1'b1, 29, rndA ^ rndB, "rndXor");
        addRow(rType(fnSlt, 25, 26, 30, 0), 1'b1, 30,
               {31'b0, (rndA[31] != rndB[31]) ? rndA[31] : (rndA < rndB)}, "rndSlt");
        addRow(jType(numRows), 1'b0, 0, 32'd0, "jumpSelf"); // parks the core
    endtask

    function automatic int nextWrite(int from);
        int r;
        r = from;
        while (r < numRows && !expWrite[r]) begin
            r++;
        end
        return r;
    endfunction

    task automatic checkWrite(int r);
        if (wbAddr !== expReg[r]) begin
            mismatches++;
            $display("ERROR %s: register expected r%0d actual r%0d",
                     testName[r], expReg[r], wbAddr);
        end
        if (wbData !== expVal[r]) begin
            mismatches++;
            $display("ERROR %s: value expected %h actual %h", testName[r], expVal[r], wbData);
        end
    endtask

    initial begin
        @(negedge rst);
        repeat (numRows * 4 + 40) @(posedge clk);
        $display("timeout: the expected write-backs did not all appear in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int row;
        clk         = 1'b0;
        rst         = 1'b1;
        numRows     = 0;
        mismatches  = 0;
        unexpected  = 0;
        assertFails = 0;
        void'($urandom(32'hb7ef));
        buildProgram();
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
            #1;
            if (wbValid !== 1'b0) begin
                mismatches++;
                $display("ERROR reset: wbValid expected 0 actual %b", wbValid);
            end
            if (imemAddr !== 32'h0) begin
                mismatches++;
                $display("ERROR firstFetch: imemAddr expected %h actual %h", 32'h0, imemAddr);
            end
        end
        rst = 1'b0;
        row = nextWrite(0);
        while (row < numRows) begin
            @(negedge clk);
            if (wbValid === 1'b1) begin
                checkWrite(row);
                row = nextWrite(row + 1);
            end
        end
        repeat (drainCycles) begin
            @(negedge clk);
            if (wbValid !== 1'b0) begin
                unexpected++;
                $display("unexpected register write r%0d = %h after the last expected write",
                         wbAddr, wbData);
            end
        end
        assertFails = dut0.chk0.failCount;
        $display("errors: mismatches %0d, unexpected writes %0d, assertion failures %0d",
                 mismatches, unexpected, assertFails);
        if (mismatches == 0 && unexpected == 0 && assertFails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/pipeCpu_chk.sv */
`default_nettype none

module pipeCpuChk
    import isaPkg::*;
(
    input wire logic     clk,
    input wire logic     rst,
    input wire logic     wbValid,
    input wire regAddr_t wbAddr,
    input wire word_t    imemAddr,
    input wire logic     stall
);

    int unsigned failCount = 0;

    noWriteR0: assert property (@(posedge clk) disable iff (rst) wbValid |-> wbAddr != '0)
        else begin
            $error("write-back valid with destination r0");
            failCount = failCount + 1;
        end

    quietInReset: assert property (@(posedge clk) rst |-> !wbValid)
        else begin
            $error("write-back valid while in reset");
            failCount = failCount + 1;
        end

    alignedFetch: assert property (@(posedge clk) imemAddr[1:0] == 2'b00)
        else begin
            $error("fetch address not word aligned");
            failCount = failCount + 1;
        end

    // pc must freeze while decode waits on a hazard
    stallHoldsPc: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(imemAddr))
        else begin
            $error("fetch address moved during a stall");
            failCount = failCount + 1;
        end

endmodule

bind pipeCpu pipeCpuChk chk0 (
    .clk      (clk),
    .rst      (rst),
    .wbValid  (wbValid),
    .wbAddr   (wbAddr),
    .imemAddr (imemAddr),
    .stall    (stall)
);

`default_nettype wire
